// File: common/mult_pkg.sv
/*
 * Shared widths, operator and state encodings, and the request and
 * control structs of the subword multiplier. Every multiplier file
 * refers to these by scoped name.
 */

package mult_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Data word, halfword and byte lane widths
  localparam int WORD_W  = 32;
  localparam int HALF_W  = 16;
  localparam int BYTE_W  = 8;

  // Shift immediate width
  localparam int SHAMT_W = 5;

  // Realignment shift of the first and third high-half steps
  localparam logic [SHAMT_W-1:0] MULH_STEP_SHIFT = 5'd16;

  //////////////////////////////////////////////////////////////////////
  // Plain vector types
  //////////////////////////////////////////////////////////////////////

  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [SHAMT_W-1:0] shamt_t;

  // Bit 0 marks operand A signed, bit 1 marks operand B signed
  typedef logic [1:0]         sign_sel_t;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Multiplier operators, code 3'b111 is undefined
  typedef enum logic [2:0] {
    MUL_MAC32 = 3'b000,
    MUL_MSU32 = 3'b001,
    MUL_I     = 3'b010,
    MUL_IR    = 3'b011,
    MUL_DOT8  = 3'b100,
    MUL_DOT16 = 3'b101,
    MUL_H     = 3'b110
  } mult_op_e;

  // High-half multiply sequencer states
  typedef enum logic [2:0] {
    IDLE,
    STEP0,
    STEP1,
    STEP2,
    FINISH
  } mulh_state_e;

  //////////////////////////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////////////////////////

  // Scalar unit request, subword picks the upper halves
  typedef struct packed {
    word_t     op_a;
    word_t     op_b;
    word_t     op_c;
    shamt_t    imm;
    logic      subword;
    sign_sel_t sign;
  } scalar_req_t;

  // Dot-product unit request
  typedef struct packed {
    word_t     op_a;
    word_t     op_b;
    word_t     op_c;
    sign_sel_t sign;
  } dot_req_t;

  // Sequencer overrides for the halfword datapath
  typedef struct packed {
    logic      active;
    shamt_t    imm;
    logic [1:0] subword;
    sign_sel_t sign;
    logic      shift_arith;
    // Registered carry, bit 32 of the accumulator
    logic      carry;
  } mulh_ctrl_t;

endpackage

// File: compile.f
+incdir+testbench
common/mult_pkg.sv
scalar_mult/mulh_seq.sv
scalar_mult/scalar_mult.sv
dot_mult/dot_mult.sv
hdl/mult_result_sel.sv
hdl/riscv_mult.sv
testbench/tb_mult.sv

// File: dot_mult/dot_mult.sv
/*
 * Dot-product unit. Computes the four-lane 8-bit and the two-lane
 * 16-bit dot products with accumulator, both on every cycle.
 */

module dot_mult (
  input  mult_pkg::dot_req_t dot_req_i,
  output mult_pkg::word_t    dot8_result_o,
  output mult_pkg::word_t    dot16_result_o
);

  //////////////////////////////////////////////////////////////////////
  // Byte lanes
  //////////////////////////////////////////////////////////////////////

  // 9-bit lanes, sign or zero extended per operand
  logic [mult_pkg::WORD_W/mult_pkg::BYTE_W-1:0][mult_pkg::BYTE_W:0] byte_a;
  logic [mult_pkg::WORD_W/mult_pkg::BYTE_W-1:0][mult_pkg::BYTE_W:0] byte_b;
  logic [mult_pkg::WORD_W/mult_pkg::BYTE_W-1:0][mult_pkg::WORD_W-1:0] byte_prod;

  // 17-bit halfword lanes
  logic [mult_pkg::WORD_W/mult_pkg::HALF_W-1:0][mult_pkg::HALF_W:0] half_a;
  logic [mult_pkg::WORD_W/mult_pkg::HALF_W-1:0][mult_pkg::HALF_W:0] half_b;
  logic [mult_pkg::WORD_W/mult_pkg::HALF_W-1:0][mult_pkg::WORD_W-1:0] half_prod;

  for (genvar i = 0; i < mult_pkg::WORD_W / mult_pkg::BYTE_W; i++) begin : g_byte
    assign byte_a[i] = {dot_req_i.sign[0] & dot_req_i.op_a[i*mult_pkg::BYTE_W+7],
                        dot_req_i.op_a[i*mult_pkg::BYTE_W +: mult_pkg::BYTE_W]};
    assign byte_b[i] = {dot_req_i.sign[1] & dot_req_i.op_b[i*mult_pkg::BYTE_W+7],
                        dot_req_i.op_b[i*mult_pkg::BYTE_W +: mult_pkg::BYTE_W]};

    // Widen to a word so the product wraps like the final sum
    assign byte_prod[i] =
      {{(mult_pkg::WORD_W-mult_pkg::BYTE_W-1){byte_a[i][mult_pkg::BYTE_W]}}, byte_a[i]} *
      {{(mult_pkg::WORD_W-mult_pkg::BYTE_W-1){byte_b[i][mult_pkg::BYTE_W]}}, byte_b[i]};
  end

  //////////////////////////////////////////////////////////////////////
  // Halfword lanes
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < mult_pkg::WORD_W / mult_pkg::HALF_W; i++) begin : g_half
    assign half_a[i] = {dot_req_i.sign[0] & dot_req_i.op_a[i*mult_pkg::HALF_W+15],
                        dot_req_i.op_a[i*mult_pkg::HALF_W +: mult_pkg::HALF_W]};
    assign half_b[i] = {dot_req_i.sign[1] & dot_req_i.op_b[i*mult_pkg::HALF_W+15],
                        dot_req_i.op_b[i*mult_pkg::HALF_W +: mult_pkg::HALF_W]};

    // Only the low word of each lane product reaches the result
    assign half_prod[i] =
      {{(mult_pkg::WORD_W-mult_pkg::HALF_W-1){half_a[i][mult_pkg::HALF_W]}}, half_a[i]} *
      {{(mult_pkg::WORD_W-mult_pkg::HALF_W-1){half_b[i][mult_pkg::HALF_W]}}, half_b[i]};
  end

  //////////////////////////////////////////////////////////////////////
  // Lane sums with accumulator
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    dot8_result_o = dot_req_i.op_c;
    for (int i = 0; i < mult_pkg::WORD_W / mult_pkg::BYTE_W; i++) begin
      dot8_result_o = dot8_result_o + byte_prod[i];
    end
  end

  always_comb begin
    dot16_result_o = dot_req_i.op_c;
    for (int i = 0; i < mult_pkg::WORD_W / mult_pkg::HALF_W; i++) begin
      dot16_result_o = dot16_result_o + half_prod[i];
    end
  end

endmodule

// File: hdl/mult_result_sel.sv
/*
 * Final result selector. Decodes the operator and forwards the scalar
 * or the matching dot-product result.
 */

module mult_result_sel (
  input  mult_pkg::mult_op_e operator_i,
  input  mult_pkg::word_t    scalar_result_i,
  input  mult_pkg::word_t    dot8_result_i,
  input  mult_pkg::word_t    dot16_result_i,
  output mult_pkg::word_t    result_o
);

  always_comb begin
    // Undefined operators read as zero
    result_o = '0;

    case (operator_i)
      // MAC/MSU and all halfword forms share the scalar output
      mult_pkg::MUL_MAC32,
      mult_pkg::MUL_MSU32,
      mult_pkg::MUL_I,
      mult_pkg::MUL_IR,
      mult_pkg::MUL_H: begin
        result_o = scalar_result_i;
      end

      mult_pkg::MUL_DOT8: begin
        result_o = dot8_result_i;
      end

      mult_pkg::MUL_DOT16: begin
        result_o = dot16_result_i;
      end

      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

// File: hdl/riscv_mult.sv
/*
 * Multiplier top level. Connects the scalar unit, the dot-product unit
 * and the result selector. Only MUL_H takes several cycles; every other
 * operator is combinational with ready_o high.
 */

module riscv_mult (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  enable_i,
  input  mult_pkg::mult_op_e    operator_i,
  input  mult_pkg::scalar_req_t scalar_req_i,
  input  mult_pkg::dot_req_t    dot_req_i,
  input  logic                  ex_ready_i,
  output mult_pkg::word_t       result_o,
  output logic                  multicycle_o,
  output logic                  ready_o
);

  // Unit results ahead of the selector
  mult_pkg::word_t scalar_result;
  mult_pkg::word_t dot8_result;
  mult_pkg::word_t dot16_result;

  // Scalar side, owns the high-half handshake
  scalar_mult i_scalar_mult (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable_i       (enable_i),
    .operator_i     (operator_i),
    .req_i          (scalar_req_i),
    .ex_ready_i     (ex_ready_i),
    .scalar_result_o(scalar_result),
    .multicycle_o   (multicycle_o),
    .ready_o        (ready_o)
  );

  // Dot products, purely combinational
  dot_mult i_dot_mult (
    .dot_req_i     (dot_req_i),
    .dot8_result_o (dot8_result),
    .dot16_result_o(dot16_result)
  );

  mult_result_sel i_mult_result_sel (
    .operator_i     (operator_i),
    .scalar_result_i(scalar_result),
    .dot8_result_i  (dot8_result),
    .dot16_result_i (dot16_result),
    .result_o       (result_o)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal \
  --top-module tb_mult \
  -f compile.f \
  -Mdir obj_dir \
  -o tb_mult_sim

# The log decides pass or fail
./obj_dir/tb_mult_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation finished without failures"

// File: scalar_mult/mulh_seq.sv
/*
 * High-half multiply sequencer. Steps the halfword datapath through
 * four partial products and holds the carry between steps. Starts on
 * MUL_H with enable and waits for ex_ready_i in FINISH.
 */

module mulh_seq (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 enable_i,
  input  mult_pkg::mult_op_e   operator_i,
  input  mult_pkg::sign_sel_t  sign_i,
  input  logic                 mac_carry_i,
  input  logic                 ex_ready_i,
  output mult_pkg::mulh_ctrl_t ctrl_o,
  output logic                 multicycle_o,
  output logic                 ready_o
);

  mult_pkg::mulh_state_e state_q;
  mult_pkg::mulh_state_e state_d;

  // Carry of the 33-bit partial sum
  logic carry_q;
  logic save;
  logic clear_carry;

  //////////////////////////////////////////////////////////////////////
  // Next state and datapath control
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d            = state_q;
    ctrl_o.active      = 1'b1;
    ctrl_o.imm         = '0;
    ctrl_o.subword     = 2'b00;
    ctrl_o.sign        = 2'b00;
    ctrl_o.shift_arith = 1'b0;
    ctrl_o.carry       = carry_q;
    save               = 1'b0;
    clear_carry        = 1'b0;
    multicycle_o       = 1'b0;
    ready_o            = 1'b0;

    unique case (state_q)
      mult_pkg::IDLE: begin
        // Datapath belongs to the normal operators here
        ctrl_o.active = 1'b0;
        ready_o       = 1'b1;
        if (enable_i && (operator_i == mult_pkg::MUL_H)) begin
          ready_o = 1'b0;
          state_d = mult_pkg::STEP0;
        end
      end

      mult_pkg::STEP0: begin
        // AL*BL, always unsigned and never overflows
        multicycle_o = 1'b1;
        ctrl_o.imm   = mult_pkg::MULH_STEP_SHIFT;
        state_d      = mult_pkg::STEP1;
      end

      mult_pkg::STEP1: begin
        // AL*BH, signed only if B is signed
        multicycle_o       = 1'b1;
        ctrl_o.sign        = {sign_i[1], 1'b0};
        ctrl_o.subword     = 2'b10;
        ctrl_o.shift_arith = 1'b1;
        // Keep bit 32 as sign extension of the unshifted sum
        save               = 1'b1;
        state_d            = mult_pkg::STEP2;
      end

      mult_pkg::STEP2: begin
        // AH*BL, signed only if A is signed
        multicycle_o       = 1'b1;
        ctrl_o.sign        = {1'b0, sign_i[0]};
        ctrl_o.subword     = 2'b01;
        ctrl_o.imm         = mult_pkg::MULH_STEP_SHIFT;
        ctrl_o.shift_arith = 1'b1;
        // Upper bits are shifted back in, carry no longer needed
        save               = 1'b1;
        clear_carry        = 1'b1;
        state_d            = mult_pkg::FINISH;
      end

      mult_pkg::FINISH: begin
        // AH*BH with the caller's signedness, result is valid
        ctrl_o.sign    = sign_i;
        ctrl_o.subword = 2'b11;
        ready_o        = 1'b1;
        if (ex_ready_i) begin
          state_d = mult_pkg::IDLE;
        end
      end

      default: begin
        state_d = mult_pkg::IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // State and carry registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= mult_pkg::IDLE;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (save) begin
        carry_q <= ~clear_carry & mac_carry_i;
      end else if (ex_ready_i) begin
        // Next instruction starts with a clean carry
        carry_q <= 1'b0;
      end
    end
  end

endmodule

// File: scalar_mult/scalar_mult.sv
/*
 * Scalar multiplier: halfword multiply-accumulate with shift and
 * rounding, and the 32-bit MAC/MSU. The high-half multiply reuses the
 * halfword datapath under control of the mulh_seq child.
 */

module scalar_mult (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  enable_i,
  input  mult_pkg::mult_op_e    operator_i,
  input  mult_pkg::scalar_req_t req_i,
  input  logic                  ex_ready_i,
  output mult_pkg::word_t       scalar_result_o,
  output logic                  multicycle_o,
  output logic                  ready_o
);

  mult_pkg::mulh_ctrl_t mulh_ctrl;

  // 17-bit extended halves, 33-bit addend, 34-bit sums
  logic [mult_pkg::HALF_W:0]   short_op_a;
  logic [mult_pkg::HALF_W:0]   short_op_b;
  logic [mult_pkg::WORD_W:0]   short_op_c;
  logic [mult_pkg::WORD_W+1:0] short_mul;
  logic [mult_pkg::WORD_W+1:0] short_mac;
  logic [mult_pkg::WORD_W+1:0] short_shift_in;
  logic [mult_pkg::WORD_W+1:0] short_result;
  mult_pkg::word_t             round_unit;
  mult_pkg::word_t             short_round;
  logic                        short_msb1;
  logic                        short_msb0;

  // Settings after the high-half override
  mult_pkg::shamt_t            short_imm;
  logic [1:0]                  short_subword;
  mult_pkg::sign_sel_t         short_sign;
  logic                        short_shift_arith;

  // Partial sum carried between high-half steps
  mult_pkg::word_t             mulh_acc_q;

  mult_pkg::word_t             int_op_a;
  mult_pkg::word_t             int_op_b;
  mult_pkg::word_t             int_result;
  logic                        int_is_msu;
  logic                        int_path;

  mulh_seq i_mulh_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .enable_i    (enable_i),
    .operator_i  (operator_i),
    .sign_i      (req_i.sign),
    .mac_carry_i (short_mac[mult_pkg::WORD_W]),
    .ex_ready_i  (ex_ready_i),
    .ctrl_o      (mulh_ctrl),
    .multicycle_o(multicycle_o),
    .ready_o     (ready_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Halfword multiply-accumulate
  //////////////////////////////////////////////////////////////////////

  assign short_imm         = mulh_ctrl.active ? mulh_ctrl.imm         : req_i.imm;
  assign short_subword     = mulh_ctrl.active ? mulh_ctrl.subword     : {2{req_i.subword}};
  assign short_sign        = mulh_ctrl.active ? mulh_ctrl.sign        : req_i.sign;
  // Scalar signedness is never A unsigned with B signed, so A decides
  assign short_shift_arith = mulh_ctrl.active ? mulh_ctrl.shift_arith : req_i.sign[0];

  // Rounding adds half of two to the power imm
  assign round_unit  = mult_pkg::word_t'(1) << req_i.imm;
  assign short_round = (operator_i == mult_pkg::MUL_IR) ? (round_unit >> 1) : '0;

  // Half selection and extension by operand signedness
  assign short_op_a = {short_sign[0] & short_op_a[mult_pkg::HALF_W-1],
                       short_subword[0] ? req_i.op_a[31:16] : req_i.op_a[15:0]};
  assign short_op_b = {short_sign[1] & short_op_b[mult_pkg::HALF_W-1],
                       short_subword[1] ? req_i.op_b[31:16] : req_i.op_b[15:0]};

  // High-half steps accumulate onto the stored sum and carry
  assign short_op_c = mulh_ctrl.active ? {mulh_ctrl.carry, mulh_acc_q}
                                       : {req_i.op_c[mult_pkg::WORD_W-1], req_i.op_c};

  // Low 34 bits of the sign-extended product
  assign short_mul = {{(mult_pkg::HALF_W+1){short_op_a[mult_pkg::HALF_W]}}, short_op_a} *
                     {{(mult_pkg::HALF_W+1){short_op_b[mult_pkg::HALF_W]}}, short_op_b};

  assign short_mac = {short_op_c[mult_pkg::WORD_W], short_op_c} + short_mul +
                     {2'b00, short_round};

  // Normal ops extend from bit 31, the sequence keeps bits 33:32
  assign short_msb1 = mulh_ctrl.active ? short_mac[33] : short_mac[31];
  assign short_msb0 = mulh_ctrl.active ? short_mac[32] : short_mac[31];

  assign short_shift_in = {short_shift_arith & short_msb1, short_shift_arith & short_msb0,
                           short_mac[mult_pkg::WORD_W-1:0]};
  assign short_result   = $signed(short_shift_in) >>> short_imm;

  // Cleared while idle, loaded after each of the three steps
  always_ff @(posedge clk) begin
    if (!mulh_ctrl.active) begin
      mulh_acc_q <= '0;
    end else if (multicycle_o) begin
      mulh_acc_q <= short_result[mult_pkg::WORD_W-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // 32-bit MAC and MSU
  //////////////////////////////////////////////////////////////////////

  // c - a*b as c + (~a)*b + b
  assign int_is_msu = (operator_i == mult_pkg::MUL_MSU32);
  assign int_op_a   = req_i.op_a ^ {mult_pkg::WORD_W{int_is_msu}};
  assign int_op_b   = req_i.op_b & {mult_pkg::WORD_W{int_is_msu}};
  assign int_result = req_i.op_c + int_op_b + int_op_a * req_i.op_b;

  assign int_path        = (operator_i == mult_pkg::MUL_MAC32) || int_is_msu;
  assign scalar_result_o = int_path ? int_result : short_result[mult_pkg::WORD_W-1:0];

endmodule

// File: testbench/tb_mult_model.svh
/*
 * Reference arithmetic for the multiplier testbench. Each function gives
 * the expected result of one operator, computed from the operator's rules.
 */

`ifndef TB_MULT_MODEL_SVH
`define TB_MULT_MODEL_SVH

// 32-bit multiply-accumulate, wraps modulo 2^32
function automatic logic [31:0] mac32_sum(input logic [31:0] a, b, c);
  return c + a * b;
endfunction

// 32-bit multiply-subtract
function automatic logic [31:0] msu32_diff(input logic [31:0] a, b, c);
  return c - a * b;
endfunction

// Halfword product plus c and optional rounding, shifted as a 32-bit accumulator
function automatic logic [31:0] halfword_mac(input logic [31:0] a, b, c,
                                             input logic [4:0] imm, input logic sub,
                                             input logic [1:0] sign, input logic rnd);
  logic [15:0] sel_a;
  logic [15:0] sel_b;
  logic [31:0] pa;
  logic [31:0] pb;
  logic [31:0] rnd_add;
  logic [31:0] acc;
  sel_a   = sub ? a[31:16] : a[15:0];
  sel_b   = sub ? b[31:16] : b[15:0];
  pa      = sign[0] ? {{16{sel_a[15]}}, sel_a} : {16'b0, sel_a};
  pb      = sign[1] ? {{16{sel_b[15]}}, sel_b} : {16'b0, sel_b};
  // Half of two to the power imm
  rnd_add = rnd ? ((32'd1 << imm) >> 1) : 32'd0;
  acc     = pa * pb + c + rnd_add;
  if (sign[0]) begin
    return $signed(acc) >>> imm;
  end else begin
    return acc >> imm;
  end
endfunction

// Upper word of the full 64-bit product
function automatic logic [31:0] mulh_upper(input logic [31:0] a, b, input logic [1:0] sign);
  logic [63:0] wa;
  logic [63:0] wb;
  logic [63:0] prod;
  wa   = sign[0] ? {{32{a[31]}}, a} : {32'b0, a};
  wb   = sign[1] ? {{32{b[31]}}, b} : {32'b0, b};
  prod = wa * wb;
  return prod[63:32];
endfunction

// Four byte lanes plus accumulator
function automatic logic [31:0] dot8_sum(input logic [31:0] a, b, c, input logic [1:0] sign);
  logic [31:0] sum;
  logic [7:0]  ba;
  logic [7:0]  bb;
  sum = c;
  for (int i = 0; i < 4; i++) begin
    ba  = a[i*8 +: 8];
    bb  = b[i*8 +: 8];
    sum = sum + (sign[0] ? {{24{ba[7]}}, ba} : {24'b0, ba}) *
                (sign[1] ? {{24{bb[7]}}, bb} : {24'b0, bb});
  end
  return sum;
endfunction

// Two halfword lanes plus accumulator
function automatic logic [31:0] dot16_sum(input logic [31:0] a, b, c, input logic [1:0] sign);
  logic [31:0] sum;
  logic [15:0] ha;
  logic [15:0] hb;
  sum = c;
  for (int i = 0; i < 2; i++) begin
    ha  = a[i*16 +: 16];
    hb  = b[i*16 +: 16];
    sum = sum + (sign[0] ? {{16{ha[15]}}, ha} : {16'b0, ha}) *
                (sign[1] ? {{16{hb[15]}}, hb} : {16'b0, hb});
  end
  return sum;
endfunction

`endif

// File: testbench/tb_mult.sv
/*
 * Testbench for the multiplier top level. Drives random operators and
 * operands, tracks the high-half handshake and checks every response
 * with concurrent assertions sampled on the falling clock edge.
 */

module tb_mult;

  localparam int NUM_OPS        = 2000;
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int CLK_HALF       = 4;
  localparam int RESET_CYCLES   = 8;
  // Edges from the start edge until FINISH
  localparam int MAX_WAIT       = 4;

  logic                  clk;
  logic                  rst_n;
  logic                  enable_i;
  logic                  ex_ready_i;
  mult_pkg::mult_op_e    operator_i;
  mult_pkg::scalar_req_t scalar_req_i;
  mult_pkg::dot_req_t    dot_req_i;
  mult_pkg::word_t       result_o;
  logic                  multicycle_o;
  logic                  ready_o;

  // Check enables set together with the stimulus
  logic                  idle_chk;
  logic                  comb_chk;
  int                    mulh_phase;
  mult_pkg::word_t       exp_result;
  int                    cycle_cnt;
  int unsigned           seed_val;

  `include "tb_mult_model.svh"

  riscv_mult i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .enable_i    (enable_i),
    .operator_i  (operator_i),
    .scalar_req_i(scalar_req_i),
    .dot_req_i   (dot_req_i),
    .ex_ready_i  (ex_ready_i),
    .result_o    (result_o),
    .multicycle_o(multicycle_o),
    .ready_o     (ready_o)
  );

  always #(CLK_HALF) clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and run limit
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("ERR time %0t: %s expected %h, got %h", $time, sig, exp_val, act_val);
    abort_run();
  endtask

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Idle and single-cycle operators
  a_idle_ready: assert property (@(negedge clk) disable iff (!rst_n) idle_chk |-> ready_o)
    else report_mismatch("ready_o", 32'd1, {31'd0, ready_o});
  a_idle_mc: assert property (@(negedge clk) disable iff (!rst_n) idle_chk |-> !multicycle_o)
    else report_mismatch("multicycle_o", 32'd0, {31'd0, multicycle_o});
  a_comb_result: assert property (@(negedge clk) disable iff (!rst_n)
    comb_chk |-> (result_o == exp_result))
    else report_mismatch("result_o", exp_result, result_o);

  // High-half steps in phases 1 to 3 after the start edge
  a_busy_mc: assert property (@(negedge clk) disable iff (!rst_n)
    (mulh_phase >= 1 && mulh_phase <= 3) |-> multicycle_o)
    else report_mismatch("multicycle_o", 32'd1, {31'd0, multicycle_o});
  a_busy_ready: assert property (@(negedge clk) disable iff (!rst_n)
    (mulh_phase >= 1 && mulh_phase <= 3) |-> !ready_o)
    else report_mismatch("ready_o", 32'd0, {31'd0, ready_o});

  // FINISH holds result and ready until acceptance
  a_fin_ready: assert property (@(negedge clk) disable iff (!rst_n)
    (mulh_phase >= 4) |-> ready_o)
    else report_mismatch("ready_o", 32'd1, {31'd0, ready_o});
  a_fin_mc: assert property (@(negedge clk) disable iff (!rst_n)
    (mulh_phase >= 4) |-> !multicycle_o)
    else report_mismatch("multicycle_o", 32'd0, {31'd0, multicycle_o});
  a_fin_result: assert property (@(negedge clk) disable iff (!rst_n)
    (mulh_phase >= 4) |-> (result_o == exp_result))
    else report_mismatch("result_o", exp_result, result_o);

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Scalar signedness never uses A unsigned with B signed
  function automatic mult_pkg::sign_sel_t pick_scalar_sign();
    case ($urandom % 3)
      0:       return 2'b00;
      1:       return 2'b01;
      default: return 2'b11;
    endcase
  endfunction

  task automatic randomize_requests();
    scalar_req_i.op_a    = $urandom;
    scalar_req_i.op_b    = $urandom;
    scalar_req_i.op_c    = $urandom;
    scalar_req_i.imm     = mult_pkg::shamt_t'($urandom % 32);
    scalar_req_i.subword = 1'($urandom % 2);
    scalar_req_i.sign    = pick_scalar_sign();
    dot_req_i.op_a       = $urandom;
    dot_req_i.op_b       = $urandom;
    dot_req_i.op_c       = $urandom;
    dot_req_i.sign       = mult_pkg::sign_sel_t'($urandom % 4);
  endtask

  task automatic apply_comb_op(input mult_pkg::mult_op_e op);
    operator_i = op;
    enable_i   = 1'b1;
    ex_ready_i = 1'b1;
    mulh_phase = 0;
    case (op)
      mult_pkg::MUL_MAC32: exp_result = mac32_sum(scalar_req_i.op_a, scalar_req_i.op_b,
                                                  scalar_req_i.op_c);
      mult_pkg::MUL_MSU32: exp_result = msu32_diff(scalar_req_i.op_a, scalar_req_i.op_b,
                                                   scalar_req_i.op_c);
      mult_pkg::MUL_I, mult_pkg::MUL_IR: begin
        exp_result = halfword_mac(scalar_req_i.op_a, scalar_req_i.op_b, scalar_req_i.op_c,
                                  scalar_req_i.imm, scalar_req_i.subword,
                                  scalar_req_i.sign, op == mult_pkg::MUL_IR);
      end
      mult_pkg::MUL_DOT8:  exp_result = dot8_sum(dot_req_i.op_a, dot_req_i.op_b,
                                                 dot_req_i.op_c, dot_req_i.sign);
      mult_pkg::MUL_DOT16: exp_result = dot16_sum(dot_req_i.op_a, dot_req_i.op_b,
                                                  dot_req_i.op_c, dot_req_i.sign);
      default:             exp_result = '0;
    endcase
    idle_chk = 1'b1;
    comb_chk = 1'b1;
    next_cycle();
  endtask

  // Start, wait for FINISH, hold for a random back-pressure, then accept
  task automatic run_mulh();
    int extra;
    extra      = $urandom % 4;
    operator_i = mult_pkg::MUL_H;
    enable_i   = 1'b1;
    ex_ready_i = 1'b0;
    idle_chk   = 1'b0;
    comb_chk   = 1'b0;
    mulh_phase = 0;
    exp_result = mulh_upper(scalar_req_i.op_a, scalar_req_i.op_b, scalar_req_i.sign);
    next_cycle();
    mulh_phase = 1;
    while (!ready_o) begin
      if (mulh_phase >= MAX_WAIT) begin
        $display("High-half multiply never raised ready_o after %0d cycles", MAX_WAIT);
        abort_run();
      end else begin
        next_cycle();
        mulh_phase = mulh_phase + 1;
      end
    end
    repeat (extra) begin
      next_cycle();
      mulh_phase = mulh_phase + 1;
    end
    ex_ready_i = 1'b1;
    next_cycle();
    mulh_phase = 0;
    enable_i   = 1'b0;
  endtask

  initial begin
    mult_pkg::mult_op_e op;
    seed_val     = $urandom(24);
    clk          = 1'b0;
    rst_n        = 1'b0;
    enable_i     = 1'b0;
    ex_ready_i   = 1'b0;
    operator_i   = mult_pkg::MUL_MAC32;
    scalar_req_i = '0;
    dot_req_i    = '0;
    idle_chk     = 1'b0;
    comb_chk     = 1'b0;
    mulh_phase   = 0;
    exp_result   = '0;
    cycle_cnt    = 0;

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n    = 1'b1;
    // Out of reset the unit sits idle
    idle_chk = 1'b1;
    next_cycle();

    for (int i = 0; i < NUM_OPS; i++) begin
      randomize_requests();
      op = mult_pkg::mult_op_e'(3'($urandom % 7));
      if (op == mult_pkg::MUL_H) begin
        run_mulh();
      end else begin
        apply_comb_op(op);
      end
    end

    idle_chk = 1'b0;
    comb_chk = 1'b0;
    next_cycle();
    $display("Everything OK");
    $finish;
  end

endmodule
